//--- source/uart_pkg.sv
// uart package
// widths, register map, state encodings and the packed records shared by the blocks

package uart_pkg;

  ///////////////////////////////////////////////////
  // sizes
  localparam int UART_DATA_W     = 8;   // character and bus width
  localparam int UART_FIFO_DEPTH = 16;
  localparam int UART_FIFO_CNT_W = 5;   // holds 0..16
  localparam int UART_OVERSAMPLE = 16;  // ticks per serial bit
  localparam int UART_DIV_W      = 16;

  // register offsets with 0 and 1 doubling as divisor bytes under dlab
  typedef enum logic [2:0] {
    REG_RBR_THR = 3'd0,
    REG_IER     = 3'd1,
    REG_IIR     = 3'd2,
    REG_LCR     = 3'd3,
    REG_LSR     = 3'd5,
    REG_SCR     = 3'd7
  } uart_reg_e;

  // reduced lcr whose remaining bits read as zero
  typedef struct packed {
    logic dlab;         // lcr bit 7
    logic parity_en;    // lcr bit 3
    logic parity_even;  // lcr bit 4
  } uart_lcr_t;

  // one receive fifo entry
  typedef struct packed {
    logic [UART_DATA_W-1:0] data;
    logic                   parity_err;
    logic                   frame_err;
  } uart_rx_rec_t;

  // line status bits from msb down
  typedef struct packed {
    logic fifo_err;  // always 0
    logic temt;
    logic thre;
    logic brk;       // always 0
    logic fe;
    logic pe;
    logic oe;
    logic dr;
  } uart_lsr_t;

  typedef enum logic [3:0] {
    IID_NONE = 4'b0001,
    IID_RLS  = 4'b0110,  // highest priority
    IID_RDA  = 4'b0100,
    IID_THRE = 4'b0010
  } uart_iid_e;

  ///////////////////////////////////////////////////
  // fsm encodings
  typedef enum logic [2:0] {
    TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
  } uart_tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
  } uart_rx_state_e;

endpackage

//--- source/uart_baud_gen.sv
// baud divider
// down-counter giving one oversample tick every divisor clocks

`timescale 1ns/100ps

module uart_baud_gen (
  input  logic                            clk,
  input  logic                            wb_rst_i,
  input  logic [uart_pkg::UART_DIV_W-1:0] divisor_i,
  input  logic                            restart_i,  // low divisor byte written
  output logic                            tick_o
);
  import uart_pkg::*;

  logic [UART_DIV_W-1:0] cnt;
  logic                  cnt_zero;

  assign cnt_zero = (cnt == '0);

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cnt <= '0;
    end else if (restart_i || cnt_zero) begin
      cnt <= divisor_i - 1'b1;  // preset
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // divisor of 0 stops the tick
  assign tick_o = cnt_zero && (divisor_i != '0) && !restart_i;

endmodule

//--- source/uart_fifo.sv
// synchronous fifo
// circular buffer with occupancy count, head entry visible on data_o

`timescale 1ns/100ps

module uart_fifo #(
  parameter int WIDTH = uart_pkg::UART_DATA_W
) (
  input  logic                                 clk,
  input  logic                                 wb_rst_i,
  input  logic                                 push_i,
  input  logic [WIDTH-1:0]                     data_i,
  input  logic                                 pop_i,
  output logic [WIDTH-1:0]                     data_o,
  output logic [uart_pkg::UART_FIFO_CNT_W-1:0] count_o,
  output logic                                 full_o,
  output logic                                 empty_o
);
  import uart_pkg::*;

  logic [WIDTH-1:0]             mem [UART_FIFO_DEPTH];
  logic [UART_FIFO_CNT_W-2:0]   wr_ptr;
  logic [UART_FIFO_CNT_W-2:0]   rd_ptr;
  logic                         do_push;
  logic                         do_pop;

  assign full_o  = (count_o == UART_FIFO_CNT_W'(UART_FIFO_DEPTH));
  assign empty_o = (count_o == '0);
  assign do_push = push_i && !full_o;   // push into full is dropped
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

//--- source/uart_tx.sv
// uart transmitter
// pops a character from the tx fifo and sends start, 8 data lsb first, parity, stop

`timescale 1ns/100ps

module uart_tx (
  input  logic                             clk,
  input  logic                             wb_rst_i,
  input  logic                             tick_i,
  input  uart_pkg::uart_lcr_t              lcr_i,
  input  logic                             fifo_empty_i,
  input  logic [uart_pkg::UART_DATA_W-1:0] fifo_data_i,
  output logic                             fifo_pop_o,
  output logic                             tx_busy_o,
  output logic                             stx_o
);
  import uart_pkg::*;

  typedef logic [$clog2(UART_OVERSAMPLE)-1:0] tick_cnt_t;

  uart_tx_state_e         state;
  tick_cnt_t              tick_cnt;  // ticks within the current bit
  logic [2:0]             bit_cnt;
  logic [UART_DATA_W-1:0] shreg;
  logic                   par_bit;
  logic                   bit_end;

  assign fifo_pop_o = (state == TX_IDLE) && !fifo_empty_i && tick_i;  // start bit on a tick
  assign bit_end    = tick_i && (tick_cnt == tick_cnt_t'(UART_OVERSAMPLE - 1));
  assign tx_busy_o  = (state != TX_IDLE);

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      if (state == TX_IDLE) tick_cnt <= '0;
      else if (tick_i)      tick_cnt <= tick_cnt + 1'b1;
      case (state)
        TX_IDLE:   if (fifo_pop_o) state <= TX_START;
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_cnt <= '0;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == '1) state <= lcr_i.parity_en ? TX_PARITY : TX_STOP;
          end
        end
        TX_PARITY: if (bit_end) state <= TX_STOP;
        TX_STOP:   if (bit_end) state <= TX_IDLE;
        default:   state <= TX_IDLE;
      endcase
    end
  end

  // character and its parity are taken at pop
  always_ff @(posedge clk) begin
    if (fifo_pop_o) begin
      shreg   <= fifo_data_i;
      par_bit <= (^fifo_data_i) ^ ~lcr_i.parity_even;  // odd parity inverts
    end else if (state == TX_DATA && bit_end) begin
      shreg <= {1'b0, shreg[UART_DATA_W-1:1]};  // lsb first
    end
  end

  always_comb begin
    case (state)
      TX_START:  stx_o = 1'b0;
      TX_DATA:   stx_o = shreg[0];
      TX_PARITY: stx_o = par_bit;
      default:   stx_o = 1'b1;  // idle and stop are mark
    endcase
  end

endmodule

//--- source/uart_rx.sv
// uart receiver
// two-flop input sync, mid-bit sampling, parity and stop checks, one push per frame

`timescale 1ns/100ps

module uart_rx (
  input  logic                   clk,
  input  logic                   wb_rst_i,
  input  logic                   tick_i,
  input  uart_pkg::uart_lcr_t    lcr_i,
  input  logic                   srx_i,
  output logic                   push_o,
  output uart_pkg::uart_rx_rec_t rec_o
);
  import uart_pkg::*;

  typedef logic [$clog2(UART_OVERSAMPLE)-1:0] tick_cnt_t;

  logic [1:0]             sync_q;    // metastability stages
  logic                   rx_s;
  logic                   rx_d;      // for edge detect
  uart_rx_state_e         state;
  tick_cnt_t              tick_cnt;
  logic [2:0]             bit_cnt;
  logic [UART_DATA_W-1:0] shreg;
  logic                   pe_q;
  logic                   fe_q;
  logic                   mid;

  assign rx_s = sync_q[1];
  // tick 8 of 16 counted from the falling edge
  assign mid  = tick_i && (tick_cnt == tick_cnt_t'(UART_OVERSAMPLE / 2 - 1));

  ///////////////////////////////////////////////////
  // control
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      sync_q   <= 2'b11;  // line idles high
      rx_d     <= 1'b1;
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      push_o   <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], srx_i};
      rx_d   <= rx_s;
      push_o <= 1'b0;
      if (state == RX_IDLE) tick_cnt <= '0;
      else if (tick_i)      tick_cnt <= tick_cnt + 1'b1;
      case (state)
        RX_IDLE:  if (rx_d && !rx_s) state <= RX_START;  // falling edge
        RX_START: begin
          if (mid) begin
            state   <= rx_s ? RX_IDLE : RX_DATA;  // glitch drops back to idle
            bit_cnt <= '0;
          end
        end
        RX_DATA: begin
          if (mid) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == '1) state <= lcr_i.parity_en ? RX_PARITY : RX_STOP;
          end
        end
        RX_PARITY: if (mid) state <= RX_STOP;
        RX_STOP: begin
          if (mid) begin
            state  <= RX_IDLE;
            push_o <= 1'b1;  // errored frames are pushed too
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  ///////////////////////////////////////////////////
  // data and error flags
  always_ff @(posedge clk) begin
    if (mid) begin
      case (state)
        RX_START:  pe_q <= 1'b0;
        RX_DATA:   shreg <= {rx_s, shreg[UART_DATA_W-1:1]};  // lsb arrives first
        RX_PARITY: pe_q <= rx_s != ((^shreg) ^ ~lcr_i.parity_even);
        RX_STOP:   fe_q <= !rx_s;  // stop must be high
        default:   ;
      endcase
    end
  end

  assign rec_o = '{data: shreg, parity_err: pe_q, frame_err: fe_q};

endmodule

//--- source/uart_regs.sv
// uart register block
// register map and read mux, line status, interrupt priority and int_o

`timescale 1ns/100ps

module uart_regs (
  input  logic                             clk,
  input  logic                             wb_rst_i,
  input  uart_pkg::uart_reg_e              wb_addr_i,
  input  logic [uart_pkg::UART_DATA_W-1:0] wb_dat_i,
  input  logic                             wb_we_i,
  input  logic                             wb_re_i,
  output logic [uart_pkg::UART_DATA_W-1:0] wb_dat_o,
  output uart_pkg::uart_lcr_t              lcr_o,
  output logic [uart_pkg::UART_DIV_W-1:0]  divisor_o,
  output logic                             div_restart_o,
  output logic                             tx_push_o,
  output logic                             rx_pop_o,
  input  uart_pkg::uart_rx_rec_t           rx_head_i,
  input  logic                             rx_empty_i,
  input  logic                             rx_full_i,
  input  logic                             rx_push_i,
  input  uart_pkg::uart_rx_rec_t           rx_rec_i,
  input  logic                             tx_empty_i,
  input  logic                             tx_busy_i,
  output logic                             int_o
);
  import uart_pkg::*;

  logic [3:0]             ier;  // [0] rda  [1] thre  [2] rls
  logic [UART_DATA_W-1:0] scratch;
  uart_lsr_t              lsr_q;
  uart_iid_e              iid_q;
  uart_iid_e              iid_nxt;
  logic                   thre_cond;
  logic                   thre_cond_d;
  logic                   thre_pnd;
  logic                   lsr_read;
  logic                   iir_read;
  logic                   rls_int;
  logic                   rda_int;

  // access strobes
  assign tx_push_o = wb_we_i && (wb_addr_i == REG_RBR_THR) && !lcr_o.dlab;
  assign rx_pop_o  = wb_re_i && (wb_addr_i == REG_RBR_THR) && !lcr_o.dlab;
  assign lsr_read  = wb_re_i && (wb_addr_i == REG_LSR);
  assign iir_read  = wb_re_i && (wb_addr_i == REG_IIR);

  ///////////////////////////////////////////////////
  // writable registers
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      lcr_o         <= '0;
      ier           <= '0;
      divisor_o     <= '0;  // no tick until programmed
      scratch       <= '0;
      div_restart_o <= 1'b0;
    end else begin
      // one cycle late so the counter reloads the new value
      div_restart_o <= wb_we_i && (wb_addr_i == REG_RBR_THR) && lcr_o.dlab;
      if (wb_we_i) begin
        case (wb_addr_i)
          REG_RBR_THR: if (lcr_o.dlab) divisor_o[UART_DATA_W-1:0] <= wb_dat_i;
          REG_IER: begin
            if (lcr_o.dlab) divisor_o[UART_DIV_W-1:UART_DATA_W] <= wb_dat_i;
            else            ier <= wb_dat_i[3:0];
          end
          REG_LCR: begin
            lcr_o.dlab        <= wb_dat_i[7];
            lcr_o.parity_even <= wb_dat_i[4];
            lcr_o.parity_en   <= wb_dat_i[3];
          end
          REG_SCR: scratch <= wb_dat_i;
          default: ;  // iir/fcr write ignored
        endcase
      end
    end
  end

  ///////////////////////////////////////////////////
  // interrupt sources
  assign rls_int   = ier[2] && (lsr_q.oe || lsr_q.pe || lsr_q.fe);
  assign rda_int   = ier[0] && !rx_empty_i;
  assign thre_cond = ier[1] && tx_empty_i;

  always_comb begin
    if (rls_int)       iid_nxt = IID_RLS;
    else if (rda_int)  iid_nxt = IID_RDA;
    else if (thre_pnd) iid_nxt = IID_THRE;
    else               iid_nxt = IID_NONE;
  end

  // status, pending flags and int_o
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      lsr_q       <= uart_lsr_t'(8'h60);  // thre and temt set
      thre_cond_d <= 1'b0;
      thre_pnd    <= 1'b0;
      iid_q       <= IID_NONE;
      int_o       <= 1'b0;
    end else begin
      lsr_q.dr   <= !rx_empty_i;
      lsr_q.thre <= tx_empty_i;
      lsr_q.temt <= tx_empty_i && !tx_busy_i;
      // a new error event wins over the clearing read
      lsr_q.oe <= (lsr_q.oe && !lsr_read) || (rx_push_i && rx_full_i);
      lsr_q.pe <= (lsr_q.pe && !lsr_read) || (rx_push_i && rx_rec_i.parity_err);
      lsr_q.fe <= (lsr_q.fe && !lsr_read) || (rx_push_i && rx_rec_i.frame_err);
      thre_cond_d <= thre_cond;
      if (tx_push_o || (iir_read && iid_q == IID_THRE))
        thre_pnd <= 1'b0;
      else if (thre_cond && !thre_cond_d)  // rising edge
        thre_pnd <= 1'b1;
      else
        thre_pnd <= thre_pnd && ier[1];  // drop when masked
      iid_q <= iid_nxt;
      int_o <= (iid_q != IID_NONE);
    end
  end

  ///////////////////////////////////////////////////
  // read mux
  always_comb begin
    case (wb_addr_i)
      REG_RBR_THR: wb_dat_o = lcr_o.dlab ? divisor_o[UART_DATA_W-1:0] : rx_head_i.data;
      REG_IER:     wb_dat_o = lcr_o.dlab ? divisor_o[UART_DIV_W-1:UART_DATA_W] : {4'b0, ier};
      REG_IIR:     wb_dat_o = {4'b0, iid_q};
      REG_LCR:     wb_dat_o = {lcr_o.dlab, 2'b0, lcr_o.parity_even, lcr_o.parity_en, 3'b0};
      REG_LSR:     wb_dat_o = lsr_q;
      REG_SCR:     wb_dat_o = scratch;
      default:     wb_dat_o = '0;
    endcase
  end

endmodule

//--- source/uart_top.sv
// uart top level
// register block, baud divider, tx/rx fifos, transmitter and receiver

`timescale 1ns/100ps

module uart_top (
  input  logic                             clk,
  input  logic                             wb_rst_i,
  input  logic [2:0]                       wb_addr_i,
  input  logic [uart_pkg::UART_DATA_W-1:0] wb_dat_i,
  output logic [uart_pkg::UART_DATA_W-1:0] wb_dat_o,
  input  logic                             wb_we_i,
  input  logic                             wb_re_i,
  input  logic                             srx_i,
  output logic                             stx_o,
  output logic                             int_o
);
  import uart_pkg::*;

  uart_lcr_t              lcr;
  logic [UART_DIV_W-1:0]  divisor;
  logic                   div_restart;
  logic                   tick;
  logic                   tx_push;
  logic                   tx_pop;
  logic                   tx_empty;
  logic                   tx_busy;
  logic [UART_DATA_W-1:0] tx_head;
  logic                   rx_push;
  logic                   rx_pop;
  logic                   rx_empty;
  logic                   rx_full;
  uart_rx_rec_t           rx_rec;
  uart_rx_rec_t           rx_head;

  uart_regs u_regs (
    .clk           (clk),
    .wb_rst_i      (wb_rst_i),
    .wb_addr_i     (uart_reg_e'(wb_addr_i)),
    .wb_dat_i      (wb_dat_i),
    .wb_we_i       (wb_we_i),
    .wb_re_i       (wb_re_i),
    .wb_dat_o      (wb_dat_o),
    .lcr_o         (lcr),
    .divisor_o     (divisor),
    .div_restart_o (div_restart),
    .tx_push_o     (tx_push),
    .rx_pop_o      (rx_pop),
    .rx_head_i     (rx_head),
    .rx_empty_i    (rx_empty),
    .rx_full_i     (rx_full),
    .rx_push_i     (rx_push),
    .rx_rec_i      (rx_rec),
    .tx_empty_i    (tx_empty),
    .tx_busy_i     (tx_busy),
    .int_o         (int_o)
  );

  uart_baud_gen u_baud (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .divisor_i (divisor),
    .restart_i (div_restart),
    .tick_o    (tick)
  );

  // tx fifo drops a push when full so its full flag stays open
  uart_fifo #(.WIDTH(UART_DATA_W)) u_tx_fifo (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .push_i   (tx_push),
    .data_i   (wb_dat_i),
    .pop_i    (tx_pop),
    .data_o   (tx_head),
    .count_o  (),
    .full_o   (),
    .empty_o  (tx_empty)
  );

  uart_tx u_tx (
    .clk          (clk),
    .wb_rst_i     (wb_rst_i),
    .tick_i       (tick),
    .lcr_i        (lcr),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_head),
    .fifo_pop_o   (tx_pop),
    .tx_busy_o    (tx_busy),
    .stx_o        (stx_o)
  );

  // rx fifo full flag feeds the overrun bit
  uart_fifo #(.WIDTH($bits(uart_rx_rec_t))) u_rx_fifo (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .push_i   (rx_push),
    .data_i   (rx_rec),
    .pop_i    (rx_pop),
    .data_o   (rx_head),
    .count_o  (),
    .full_o   (rx_full),
    .empty_o  (rx_empty)
  );

  uart_rx u_rx (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .tick_i   (tick),
    .lcr_i    (lcr),
    .srx_i    (srx_i),
    .push_o   (rx_push),
    .rec_o    (rx_rec)
  );

endmodule

//--- dv/uart_tb.sv
// uart testbench
// drives the register bus, loops tx to rx or sends generated frames, checks against a model

`timescale 1ns/100ps

module uart_tb;
  import uart_pkg::*;

  localparam int SEED      = 10504;
  localparam int MAX_DIV   = 4;
  localparam int N_CHARS   = 35;  // 12 wired, 4 errored, 17 overrun, 2 irq
  localparam int CYC_LIMIT = N_CHARS * UART_OVERSAMPLE * MAX_DIV * 11 * 2 + 2000;

  logic                   clk;
  logic                   wb_rst_i;
  logic [2:0]             wb_addr_i;
  logic [UART_DATA_W-1:0] wb_dat_i;
  logic [UART_DATA_W-1:0] wb_dat_o;
  logic                   wb_we_i;
  logic                   wb_re_i;
  logic                   srx_i;
  logic                   stx_o;
  logic                   int_o;

  logic         gen_sel;    // 1 hands srx to the frame generator
  logic         gen_line;
  int           cycles;
  int           errors;
  int           div;
  int           i;
  bit           par_en;
  bit           par_even;
  bit           exp_oe;     // model overrun
  uart_rx_rec_t exp_q[$];   // model rx fifo
  uart_rx_rec_t rec;
  logic [7:0]   val;
  logic [7:0]   rd;
  logic [7:0]   lo_b;
  logic [7:0]   hi_b;
  int unsigned  seed_dummy;

  assign srx_i = gen_sel ? gen_line : stx_o;  // wired loop otherwise

  uart_top uut (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_we_i   (wb_we_i),
    .wb_re_i   (wb_re_i),
    .srx_i     (srx_i),
    .stx_o     (stx_o),
    .int_o     (int_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      abort_run("timeout");
    end
  end

  //////////////////////////////////////////////////
  // failure and compare tasks
  task automatic abort_run(input string why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%02h act=%02h", $time, name, exp, act);
      abort_run("byte mismatch");
    end
  endtask

  task automatic check_lsr(input uart_lsr_t exp, input uart_lsr_t act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t lsr exp=%08b act=%08b", $time, exp, act);
      abort_run("lsr mismatch");
    end
  endtask

  task automatic check_iid(input uart_iid_e exp, input uart_iid_e act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t iir exp=%s(%04b) act=%04b", $time, exp.name(), exp, act);
      abort_run("iir mismatch");
    end
  endtask

  task automatic check_int(input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t int_o exp=%b act=%b", $time, exp, act);
      abort_run("int_o mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // bus access
  task automatic bus_write(input uart_reg_e addr, input logic [7:0] data);
    @(posedge clk);
    wb_addr_i <= addr;
    wb_dat_i  <= data;
    wb_we_i   <= 1'b1;
    @(posedge clk);
    wb_we_i   <= 1'b0;  // write lands on this edge
  endtask

  // strobe set means the access has side effects
  task automatic bus_read(input uart_reg_e addr, input bit strobe, output logic [7:0] data);
    @(posedge clk);
    wb_addr_i <= addr;
    wb_re_i   <= strobe;
    @(negedge clk);
    data = wb_dat_o;  // comb read settles by the negedge
    @(posedge clk);
    wb_re_i   <= 1'b0;
  endtask

  task automatic program_line(input int d, input bit pen, input bit peven);
    bus_write(REG_LCR, 8'h80);
    bus_write(REG_IER, 8'(d >> 8));   // high byte first
    bus_write(REG_RBR_THR, 8'(d));    // low byte restarts the count
    bus_write(REG_LCR, {3'b000, peven, pen, 3'b000});
  endtask

  //////////////////////////////////////////////////
  // model
  function automatic logic par_bit(input logic [7:0] d);
    return par_even ? ^d : ~^d;  // even total ones for even parity
  endfunction

  // transmitter is idle in every status check
  function automatic uart_lsr_t model_lsr(input bit dr, input bit oe, input bit pe, input bit fe);
    uart_lsr_t l;
    l      = '0;
    l.temt = 1'b1;
    l.thre = 1'b1;
    l.dr   = dr;
    l.oe   = oe;
    l.pe   = pe;
    l.fe   = fe;
    return l;
  endfunction

  function automatic uart_rx_rec_t make_rec(input logic [7:0] d, input bit pe, input bit fe);
    uart_rx_rec_t r;
    r.data       = d;
    r.parity_err = pe;
    r.frame_err  = fe;
    return r;
  endfunction

  task automatic drive_bit(input logic b);
    @(posedge clk);
    gen_line <= b;
    repeat (UART_OVERSAMPLE * div - 1) @(posedge clk);
  endtask

  task automatic send_frame(input logic [7:0] data, input bit bad_par, input bit bad_stop);
    int k;
    drive_bit(1'b0);  // start
    for (k = 0; k < 8; k++) drive_bit(data[k]);
    if (par_en) drive_bit(par_bit(data) ^ bad_par);
    drive_bit(!bad_stop);
    drive_bit(1'b1);  // idle gap rearms start detect after a low stop
    if (exp_q.size() < UART_FIFO_DEPTH)
      exp_q.push_back(make_rec(data, par_en && bad_par, bad_stop));
    else
      exp_oe = 1'b1;  // dropped push
  endtask

  task automatic read_char();
    uart_rx_rec_t r;
    logic [7:0]   d;
    if (exp_q.size() == 0) begin
      abort_run("read of a character the model does not hold");
    end else begin
      r = exp_q.pop_front();
      bus_read(REG_RBR_THR, 1'b1, d);
      check_byte("rbr", r.data, d);
    end
  endtask

  task automatic check_lsr_now(input uart_lsr_t exp);
    logic [7:0] d;
    bus_read(REG_LSR, 1'b0, d);
    check_lsr(exp, uart_lsr_t'(d));
  endtask

  task automatic check_iid_now(input uart_iid_e exp);
    logic [7:0] d;
    bus_read(REG_IIR, 1'b0, d);
    check_iid(exp, uart_iid_e'(d[3:0]));
  endtask

  // polls lsr without side effects until the bit is set
  task automatic wait_lsr_bit(input int bit_idx);
    logic [7:0] d;
    do bus_read(REG_LSR, 1'b0, d); while (!d[bit_idx]);
  endtask

  task automatic wait_int(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (int_o !== level && n < 8);
    check_int(level, int_o);
  endtask

  //////////////////////////////////////////////////
  // sequence
  initial begin
    clk        = 1'b0;
    wb_rst_i   = 1'b1;
    wb_addr_i  = '0;
    wb_dat_i   = '0;
    wb_we_i    = 1'b0;
    wb_re_i    = 1'b0;
    gen_sel    = 1'b0;
    gen_line   = 1'b1;
    cycles     = 0;
    errors     = 0;
    exp_oe     = 1'b0;
    div        = 1;
    par_en     = 1'b0;
    par_even   = 1'b0;
    seed_dummy = $urandom(SEED);
    repeat (4) @(posedge clk);
    wb_rst_i <= 1'b0;

    // reset values
    bus_read(REG_LCR, 1'b0, val);
    check_byte("lcr", 8'h00, val);
    check_lsr_now(model_lsr(0, 0, 0, 0));
    check_iid_now(IID_NONE);
    @(negedge clk);
    check_int(1'b0, int_o);

    // scratch, ier, divisor latch
    val = 8'($urandom);
    bus_write(REG_SCR, val);
    bus_read(REG_SCR, 1'b0, rd);
    check_byte("scr", val, rd);
    val = 8'($urandom);
    bus_write(REG_IER, val);
    bus_read(REG_IER, 1'b0, rd);
    check_byte("ier", {4'h0, val[3:0]}, rd);
    bus_write(REG_LCR, 8'h80);
    bus_read(REG_LCR, 1'b0, rd);
    check_byte("lcr", 8'h80, rd);
    lo_b = 8'($urandom);
    hi_b = 8'($urandom);
    bus_write(REG_IER, hi_b);
    bus_write(REG_RBR_THR, lo_b);
    bus_read(REG_RBR_THR, 1'b0, rd);
    check_byte("dll", lo_b, rd);
    bus_read(REG_IER, 1'b0, rd);
    check_byte("dlm", hi_b, rd);
    bus_write(REG_LCR, 8'h00);
    bus_read(REG_IER, 1'b0, rd);
    check_byte("ier", {4'h0, val[3:0]}, rd);  // normal view back
    bus_write(REG_IER, 8'h00);

    // wired loop
    div      = 1 + int'($urandom % MAX_DIV);
    par_en   = 1'($urandom);
    par_even = 1'($urandom);
    program_line(div, par_en, par_even);
    for (i = 0; i < 12; i++) begin
      val = 8'($urandom);
      bus_write(REG_RBR_THR, val);
      exp_q.push_back(make_rec(val, 1'b0, 1'b0));
    end
    wait_lsr_bit(6);  // temt
    check_lsr_now(model_lsr(1, 0, 0, 0));
    while (exp_q.size() > 0) begin
      check_lsr_now(model_lsr(1, 0, 0, 0));
      read_char();
    end
    check_lsr_now(model_lsr(0, 0, 0, 0));

    // parity and framing errors
    gen_sel  <= 1'b1;
    par_en   = 1'b1;
    par_even = 1'($urandom);
    program_line(div, par_en, par_even);
    for (i = 0; i < 4; i++) begin
      send_frame(8'($urandom), i[0], i[1]);
      wait_lsr_bit(0);
      rec = exp_q[0];
      bus_read(REG_LSR, 1'b1, val);
      check_lsr(model_lsr(1, 0, rec.parity_err, rec.frame_err), uart_lsr_t'(val));
      check_lsr_now(model_lsr(1, 0, 0, 0));  // cleared by one read
      read_char();
      check_lsr_now(model_lsr(0, 0, 0, 0));
    end

    // overrun
    for (i = 0; i < 17; i++) send_frame(8'($urandom), 1'b0, 1'b0);
    check_lsr_now(model_lsr(1, exp_oe, 0, 0));
    while (exp_q.size() > 0) read_char();
    bus_read(REG_LSR, 1'b1, val);
    check_lsr(model_lsr(0, exp_oe, 0, 0), uart_lsr_t'(val));
    check_lsr_now(model_lsr(0, 0, 0, 0));

    // thre interrupt
    bus_write(REG_IER, 8'h02);
    wait_int(1'b1);
    check_iid_now(IID_THRE);
    bus_read(REG_IIR, 1'b1, val);
    check_iid(IID_THRE, uart_iid_e'(val[3:0]));
    wait_int(1'b0);
    check_iid_now(IID_NONE);

    // rda, then rls over rda
    bus_write(REG_IER, 8'h05);
    send_frame(8'($urandom), 1'b0, 1'b0);
    wait_int(1'b1);
    check_iid_now(IID_RDA);
    read_char();
    wait_int(1'b0);
    check_iid_now(IID_NONE);
    send_frame(8'($urandom), 1'b1, 1'b0);
    wait_int(1'b1);
    check_iid_now(IID_RLS);
    rec = exp_q[0];
    bus_read(REG_LSR, 1'b1, val);
    check_lsr(model_lsr(1, 0, rec.parity_err, rec.frame_err), uart_lsr_t'(val));
    check_iid_now(IID_RDA);
    read_char();
    wait_int(1'b0);
    check_iid_now(IID_NONE);

    if (errors == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("checks failed");
    end
  end

endmodule

//--- build.f
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_top.sv
dv/uart_tb.sv

//--- Makefile
# verilator build and run of the uart testbench

VERILATOR ?= verilator
TOP       ?= uart_tb
SEED_ARGS ?= +verilator+seed+10504
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
